// File: hdl/ex1Consts.svh
`ifndef EX1_CONSTS_SVH
`define EX1_CONSTS_SVH

// datapath widths
`define EX1_XLEN				64
`define EX1_VA_BITS				48
`define EX1_GR_ID_BITS			6
`define EX1_CR_ID_BITS			5

// register ids
`define EX1_GR_DLR				6'h10
`define EX1_GR_ZZR				6'h3F
`define EX1_CR_PC				5'h00
`define EX1_CR_ZZR				5'h1F

// SR flag positions
`define EX1_SR_T				0
`define EX1_SR_S				1

// command codes
`define EX1_UCMD_NOP			6'h00
`define EX1_UCMD_MOV_RM			6'h01
`define EX1_UCMD_MOV_MR			6'h02
`define EX1_UCMD_LEA_MR			6'h03
`define EX1_UCMD_MOV_RC			6'h04
`define EX1_UCMD_MOV_CR			6'h05
`define EX1_UCMD_MOV_IR			6'h06
`define EX1_UCMD_BRA			6'h08
`define EX1_UCMD_BSR			6'h09
`define EX1_UCMD_JMP			6'h0A
`define EX1_UCMD_JSR			6'h0B
`define EX1_UCMD_BRA_NB			6'h0C
`define EX1_UCMD_ALU3			6'h10
`define EX1_UCMD_OP_IXT			6'h1E
`define EX1_UCMD_INVOP			6'h3F

// control sub-op codes
`define EX1_IXT_NOP				6'h00
`define EX1_IXT_SLEEP			6'h01
`define EX1_IXT_BREAK			6'h02
`define EX1_IXT_CLRT			6'h04
`define EX1_IXT_SETT			6'h05
`define EX1_IXT_CLRS			6'h06
`define EX1_IXT_SETS			6'h07
`define EX1_IXT_NOTT			6'h08
`define EX1_IXT_NOTS			6'h09
`define EX1_IXT_RTE				6'h0C
`define EX1_IXT_TRAPA			6'h0D
`define EX1_IXT_SYSE			6'h0F

// immediate move variants, read from the low nibble of the ixt byte
`define EX1_IMM_LDI				4'h0
`define EX1_IMM_LDISH8			4'h1
`define EX1_IMM_LDISH16			4'h2
`define EX1_IMM_LDISH32			4'h3
`define EX1_IMM_JLDIX			4'h4

// memory op direction
`define EX1_MEM_DIR_NONE		2'b00
`define EX1_MEM_DIR_READ		2'b01
`define EX1_MEM_DIR_WRITE		2'b10
`define EX1_MEM_DIR_SPECIAL		2'b11

// memory status levels
`define EX1_MEM_OK_OK			2'b00
`define EX1_MEM_OK_HOLD			2'b01
`define EX1_MEM_OK_FAULT		2'b10
`define EX1_MEM_OK_READY		2'b11

// trap codes
`define EX1_TRAP_RTE			16'hFF00
`define EX1_TRAP_TRAPA_BASE		12'hC08
`define EX1_TRAP_SYSE_TAG		4'hE
`define EX1_EXC_ACTIVE_BIT		15

`endif

// File: hdl/ex1Pkg.sv
`include "ex1Consts.svh"

package ex1Pkg;

	// predication condition
	typedef enum logic [1:0] {
		CC_AL = 2'd0,
		CC_NV = 2'd1,
		CC_CT = 2'd2,
		CC_CF = 2'd3
	} ccT;

	typedef enum logic [5:0] {
		UCMD_NOP    = `EX1_UCMD_NOP,
		UCMD_MOV_RM = `EX1_UCMD_MOV_RM,
		UCMD_MOV_MR = `EX1_UCMD_MOV_MR,
		UCMD_LEA_MR = `EX1_UCMD_LEA_MR,
		UCMD_MOV_RC = `EX1_UCMD_MOV_RC,
		UCMD_MOV_CR = `EX1_UCMD_MOV_CR,
		UCMD_MOV_IR = `EX1_UCMD_MOV_IR,
		UCMD_BRA    = `EX1_UCMD_BRA,
		UCMD_BSR    = `EX1_UCMD_BSR,
		UCMD_JMP    = `EX1_UCMD_JMP,
		UCMD_JSR    = `EX1_UCMD_JSR,
		UCMD_BRA_NB = `EX1_UCMD_BRA_NB,
		UCMD_ALU3   = `EX1_UCMD_ALU3,
		UCMD_OP_IXT = `EX1_UCMD_OP_IXT,
		UCMD_INVOP  = `EX1_UCMD_INVOP
	} uCmdT;

	typedef enum logic [5:0] {
		IXT_NOP   = `EX1_IXT_NOP,
		IXT_SLEEP = `EX1_IXT_SLEEP,
		IXT_BREAK = `EX1_IXT_BREAK,
		IXT_CLRT  = `EX1_IXT_CLRT,
		IXT_SETT  = `EX1_IXT_SETT,
		IXT_CLRS  = `EX1_IXT_CLRS,
		IXT_SETS  = `EX1_IXT_SETS,
		IXT_NOTT  = `EX1_IXT_NOTT,
		IXT_NOTS  = `EX1_IXT_NOTS,
		IXT_RTE   = `EX1_IXT_RTE,
		IXT_TRAPA = `EX1_IXT_TRAPA,
		IXT_SYSE  = `EX1_IXT_SYSE
	} ixtSubT;

	typedef struct packed {
		ccT   cc;
		uCmdT cmd;
	} opCmdT;

	// control view of the ixt byte
	typedef struct packed {
		logic [1:0] rsvd;
		ixtSubT     sub;
	} ixtCtrlT;

	// memory view, size is log2 of the access bytes
	typedef struct packed {
		logic [1:0] rsvdHi;
		logic [1:0] size;
		logic       rsvdLo;
		logic       zext;
		logic [1:0] mode;
	} ixtMemT;

	typedef union packed {
		ixtCtrlT ctrl;
		ixtMemT  mem;
	} opIxtU;

	// all zero is ready and idle
	typedef struct packed {
		logic [1:0] dir;
		logic       ext;
		logic [1:0] size;
	} memOpmT;

	typedef enum logic [1:0] {
		MEM_OK    = `EX1_MEM_OK_OK,
		MEM_HOLD  = `EX1_MEM_OK_HOLD,
		MEM_FAULT = `EX1_MEM_OK_FAULT,
		MEM_READY = `EX1_MEM_OK_READY
	} memOkT;

	typedef struct packed {
		logic [`EX1_GR_ID_BITS-1:0] idRm;
		logic [`EX1_XLEN-1:0]       valRs;
		logic [`EX1_XLEN-1:0]       valRt;
		logic [`EX1_XLEN-1:0]       valRm;
		logic [`EX1_XLEN-1:0]       valCRm;
	} srcOpsT;

	typedef struct packed {
		logic [`EX1_GR_ID_BITS-1:0] id;
		logic [`EX1_XLEN-1:0]       val;
	} regWriteT;

	typedef struct packed {
		logic [`EX1_CR_ID_BITS-1:0] id;
		logic [`EX1_XLEN-1:0]       val;
	} crWriteT;

	typedef struct packed {
		logic [`EX1_VA_BITS-1:0] addr;
		memOpmT                  opm;
		logic [`EX1_XLEN-1:0]    data;
	} memReqT;

	typedef struct packed {
		logic [`EX1_XLEN-1:0] srNext;
		logic [15:0]          trap;
		logic                 hold;
		logic                 recognised;
	} ctrlResT;

	typedef struct packed {
		logic regHeld;
		logic stall;
	} holdT;

endpackage

// File: hdl/exPredicate.sv
module exPredicate (
	input  logic           clock,
	input  logic           rstN,
	input  ex1Pkg::opCmdT  opCmd,
	input  logic           srT,
	input  logic           braFlush,
	output ex1Pkg::uCmdT   effCmd
);

	logic opEnable;
	ex1Pkg::uCmdT skipCmd;

	always_comb begin
		case (opCmd.cc)
			ex1Pkg::CC_AL: opEnable = 1'b1;
			ex1Pkg::CC_NV: opEnable = 1'b0;
			ex1Pkg::CC_CT: opEnable = srT;
			ex1Pkg::CC_CF: opEnable = !srT;
			default:       opEnable = 1'b0;
		endcase
		// a flush kills whatever condition was given
		if (braFlush)
			opEnable = 1'b0;
	end

	// a skipped predicted branch must still be able to undo the fetch
	assign skipCmd = ((opCmd.cmd == ex1Pkg::UCMD_BRA) && !braFlush) ?
		ex1Pkg::UCMD_BRA_NB : ex1Pkg::UCMD_NOP;

	assign effCmd = opEnable ? opCmd.cmd : skipCmd;

	flushIsNop: assert property (@(posedge clock) disable iff (!rstN)
		braFlush |-> (effCmd == ex1Pkg::UCMD_NOP))
		else $error("flushed op did not become a NOP");

endmodule

// File: hdl/exAgu.sv
`include "ex1Consts.svh"

module exAgu (
	input  logic [`EX1_VA_BITS-1:0] base,
	input  logic [`EX1_VA_BITS-1:0] index,
	input  logic [1:0]              scale,
	output logic [`EX1_VA_BITS-1:0] addr
);

	logic [`EX1_VA_BITS-1:0] scaledIndex;

	// index scaled by access size in bytes
	always_comb begin
		case (scale)
			2'd0: scaledIndex = index;
			2'd1: scaledIndex = {index[`EX1_VA_BITS-2:0], 1'b0};
			2'd2: scaledIndex = {index[`EX1_VA_BITS-3:0], 2'b00};
			default: scaledIndex = {index[`EX1_VA_BITS-4:0], 3'b000};
		endcase
	end

	// wraps at the virtual address width
	assign addr = base + scaledIndex;

endmodule

// File: hdl/exControlOps.sv
`include "ex1Consts.svh"

module exControlOps (
	input  logic                       clock,
	input  logic                       rstN,
	input  ex1Pkg::ixtSubT             sub,
	input  logic [`EX1_XLEN-1:0]       srIn,
	input  logic [`EX1_XLEN-1:0]       dlrIn,
	input  logic [`EX1_GR_ID_BITS-1:0] rmId,
	input  logic                       inException,
	output ex1Pkg::ctrlResT            ctrl
);

	always_comb begin
		ctrl.srNext     = srIn;
		ctrl.trap       = 16'h0000;
		ctrl.hold       = 1'b0;
		ctrl.recognised = 1'b1;

		case (sub)
			ex1Pkg::IXT_NOP, ex1Pkg::IXT_SLEEP: begin
			end
			// stays stuck until the exception handler is running
			ex1Pkg::IXT_BREAK: begin
				ctrl.hold = !inException;
			end
			ex1Pkg::IXT_CLRT: begin
				ctrl.srNext[`EX1_SR_T] = 1'b0;
			end
			ex1Pkg::IXT_SETT: begin
				ctrl.srNext[`EX1_SR_T] = 1'b1;
			end
			ex1Pkg::IXT_CLRS: begin
				ctrl.srNext[`EX1_SR_S] = 1'b0;
			end
			ex1Pkg::IXT_SETS: begin
				ctrl.srNext[`EX1_SR_S] = 1'b1;
			end
			ex1Pkg::IXT_NOTT: begin
				ctrl.srNext[`EX1_SR_T] = !srIn[`EX1_SR_T];
			end
			ex1Pkg::IXT_NOTS: begin
				ctrl.srNext[`EX1_SR_S] = !srIn[`EX1_SR_S];
			end
			ex1Pkg::IXT_RTE: begin
				ctrl.trap = `EX1_TRAP_RTE;
			end
			// trap number rides in the low nibble of the Rm field
			ex1Pkg::IXT_TRAPA: begin
				ctrl.trap = {`EX1_TRAP_TRAPA_BASE, rmId[3:0]};
			end
			ex1Pkg::IXT_SYSE: begin
				ctrl.trap = {`EX1_TRAP_SYSE_TAG, dlrIn[11:0]};
			end
			default: begin
				ctrl.recognised = 1'b0;
				ctrl.hold       = 1'b1;
			end
		endcase
	end

	trapIsKnown: assert property (@(posedge clock) disable iff (!rstN)
		(ctrl.trap != 16'h0000) |-> ctrl.recognised)
		else $error("trap code raised by an unknown sub-op");

endmodule

// File: hdl/exDispatch.sv
`include "ex1Consts.svh"

module exDispatch (
	input  logic                       clock,
	input  logic                       rstN,
	input  ex1Pkg::uCmdT               effCmd,
	input  ex1Pkg::opIxtU              opIxt,
	input  ex1Pkg::srcOpsT             ops,
	input  logic [32:0]                imm,
	input  logic [`EX1_VA_BITS-1:0]    pc,
	input  logic [`EX1_VA_BITS-1:0]    lrIn,
	input  logic [`EX1_XLEN-1:0]       srIn,
	input  logic [`EX1_VA_BITS-1:0]    aguAddr,
	input  ex1Pkg::ctrlResT            ctrl,
	input  logic                       preBra,
	input  ex1Pkg::memOkT              memOk,
	output ex1Pkg::regWriteT           rnWrite,
	output ex1Pkg::crWriteT            cnWrite,
	output ex1Pkg::memReqT             memReq,
	output logic [`EX1_XLEN-1:0]       srOut,
	output logic [`EX1_VA_BITS-1:0]    lrOut,
	output logic [`EX1_GR_ID_BITS-1:0] heldIdRn,
	output ex1Pkg::holdT               exHold,
	output logic [15:0]                trapCode
);

	localparam int AddrPad = `EX1_XLEN - `EX1_VA_BITS;

	logic                    doMemOp;
	ex1Pkg::memOpmT          doMemOpm;
	logic                    doBra;
	logic [`EX1_VA_BITS-1:0] braTarget;
	logic [3:0]              imMode;

	// MOV_IR variant sits in the low nibble of the memory view
	assign imMode = {opIxt.mem.rsvdLo, opIxt.mem.zext, opIxt.mem.mode};

	always_comb begin
		rnWrite.id  = `EX1_GR_ZZR;
		rnWrite.val = '0;
		cnWrite.id  = `EX1_CR_ZZR;
		cnWrite.val = '0;
		memReq.addr = aguAddr;
		memReq.opm  = '0;
		memReq.data = ops.valRm;
		srOut       = srIn;
		lrOut       = lrIn;
		heldIdRn    = `EX1_GR_ZZR;
		exHold      = '0;
		trapCode    = 16'h0000;

		doMemOp   = 1'b0;
		doMemOpm  = '0;
		doBra     = 1'b0;
		braTarget = aguAddr;

		case (effCmd)
			ex1Pkg::UCMD_NOP: begin
			end
			ex1Pkg::UCMD_LEA_MR: begin
				rnWrite.id  = ops.idRm;
				rnWrite.val = {{AddrPad{1'b0}}, aguAddr};
			end
			ex1Pkg::UCMD_MOV_RM: begin
				doMemOp  = 1'b1;
				doMemOpm = {`EX1_MEM_DIR_WRITE, opIxt.mem.zext, opIxt.mem.size};
			end
			// load result comes back later, so the target is held
			ex1Pkg::UCMD_MOV_MR: begin
				doMemOp  = 1'b1;
				doMemOpm = {`EX1_MEM_DIR_READ, opIxt.mem.zext, opIxt.mem.size};
				heldIdRn = ops.idRm;
			end
			ex1Pkg::UCMD_ALU3: begin
				heldIdRn = ops.idRm;
			end
			ex1Pkg::UCMD_MOV_RC: begin
				cnWrite.id  = ops.idRm[`EX1_CR_ID_BITS-1:0];
				cnWrite.val = ops.valRs;
			end
			ex1Pkg::UCMD_MOV_CR: begin
				rnWrite.id  = ops.idRm;
				rnWrite.val = ops.valCRm;
			end
			ex1Pkg::UCMD_MOV_IR: begin
				rnWrite.id = ops.idRm;
				case (imMode)
					`EX1_IMM_LDI:     rnWrite.val = {{(`EX1_XLEN - 33){imm[32]}}, imm};
					`EX1_IMM_LDISH8:  rnWrite.val = {ops.valRs[55:0], imm[7:0]};
					`EX1_IMM_LDISH16: rnWrite.val = {ops.valRs[47:0], imm[15:0]};
					`EX1_IMM_LDISH32: rnWrite.val = {ops.valRs[31:0], imm[31:0]};
					default:          rnWrite.val = ops.valRt;
				endcase
			end
			// predicted taken but skipped, so refetch from the next pc
			ex1Pkg::UCMD_BRA_NB: begin
				if (preBra) begin
					doBra     = 1'b1;
					braTarget = pc;
				end
			end
			ex1Pkg::UCMD_BRA: begin
				doBra = !preBra;
			end
			ex1Pkg::UCMD_BSR: begin
				lrOut = pc;
				doBra = !preBra;
			end
			ex1Pkg::UCMD_JMP: begin
				doBra     = 1'b1;
				braTarget = ops.valRs[`EX1_VA_BITS-1:0];
			end
			ex1Pkg::UCMD_JSR: begin
				lrOut     = pc;
				doBra     = 1'b1;
				braTarget = ops.valRs[`EX1_VA_BITS-1:0];
			end
			ex1Pkg::UCMD_OP_IXT: begin
				srOut        = ctrl.srNext;
				trapCode     = ctrl.trap;
				exHold.stall = ctrl.hold;
			end
			default: begin
				exHold.stall = 1'b1;
			end
		endcase

		if (doMemOp) begin
			memReq.opm = doMemOpm;
			if (memOk == ex1Pkg::MEM_HOLD)
				exHold.stall = 1'b1;
		end

		if (doBra) begin
			cnWrite.id  = `EX1_CR_PC;
			cnWrite.val = {{AddrPad{1'b0}}, braTarget};
		end

		exHold.regHeld = (heldIdRn != `EX1_GR_ZZR);
	end

	noMemWithBranch: assert property (@(posedge clock) disable iff (!rstN)
		!((memReq.opm.dir != `EX1_MEM_DIR_NONE) && (cnWrite.id == `EX1_CR_PC)))
		else $error("memory request issued together with a PC write");

endmodule

// File: hdl/ex1Stage.sv
`include "ex1Consts.svh"

module ex1Stage (
	input  logic                       clock,
	input  logic                       rstN,
	input  ex1Pkg::opCmdT              opCmd,
	input  ex1Pkg::opIxtU              opIxt,
	input  ex1Pkg::srcOpsT             ops,
	input  logic [32:0]                imm,
	input  logic [`EX1_VA_BITS-1:0]    pc,
	input  logic [`EX1_XLEN-1:0]       srIn,
	input  logic [`EX1_XLEN-1:0]       dlrIn,
	input  logic [`EX1_VA_BITS-1:0]    lrIn,
	input  logic                       braFlush,
	input  logic                       preBra,
	input  logic                       inException,
	input  ex1Pkg::memOkT              memOk,
	output ex1Pkg::regWriteT           rnWrite,
	output ex1Pkg::crWriteT            cnWrite,
	output ex1Pkg::memReqT             memReq,
	output logic [`EX1_XLEN-1:0]       srOut,
	output logic [`EX1_VA_BITS-1:0]    lrOut,
	output logic [`EX1_GR_ID_BITS-1:0] heldIdRn,
	output ex1Pkg::holdT               exHold,
	output logic [15:0]                trapCode
);

	ex1Pkg::uCmdT            effCmd;
	logic [`EX1_VA_BITS-1:0] aguAddr;
	ex1Pkg::ctrlResT         ctrl;

	exPredicate u_predicate (
		.clock    (clock),
		.rstN     (rstN),
		.opCmd    (opCmd),
		.srT      (srIn[`EX1_SR_T]),
		.braFlush (braFlush),
		.effCmd   (effCmd)
	);

	// base from Rs, index from Rt
	exAgu u_agu (
		.base  (ops.valRs[`EX1_VA_BITS-1:0]),
		.index (ops.valRt[`EX1_VA_BITS-1:0]),
		.scale (opIxt.mem.size),
		.addr  (aguAddr)
	);

	exControlOps u_controlOps (
		.clock       (clock),
		.rstN        (rstN),
		.sub         (opIxt.ctrl.sub),
		.srIn        (srIn),
		.dlrIn       (dlrIn),
		.rmId        (ops.idRm),
		.inException (inException),
		.ctrl        (ctrl)
	);

	exDispatch u_dispatch (
		.clock    (clock),
		.rstN     (rstN),
		.effCmd   (effCmd),
		.opIxt    (opIxt),
		.ops      (ops),
		.imm      (imm),
		.pc       (pc),
		.lrIn     (lrIn),
		.srIn     (srIn),
		.aguAddr  (aguAddr),
		.ctrl     (ctrl),
		.preBra   (preBra),
		.memOk    (memOk),
		.rnWrite  (rnWrite),
		.cnWrite  (cnWrite),
		.memReq   (memReq),
		.srOut    (srOut),
		.lrOut    (lrOut),
		.heldIdRn (heldIdRn),
		.exHold   (exHold),
		.trapCode (trapCode)
	);

endmodule

// File: dv/ex1StageTb.sv
`include "ex1Consts.svh"

module ex1StageTb;

	localparam int EdgeTimeout = 20;

	logic                       clock;
	logic                       rstN;
	ex1Pkg::opCmdT              opCmd;
	ex1Pkg::opIxtU              opIxt;
	ex1Pkg::srcOpsT             ops;
	logic [32:0]                imm;
	logic [`EX1_VA_BITS-1:0]    pc;
	logic [`EX1_XLEN-1:0]       srIn;
	logic [`EX1_XLEN-1:0]       dlrIn;
	logic [`EX1_VA_BITS-1:0]    lrIn;
	logic                       braFlush;
	logic                       preBra;
	logic                       inException;
	ex1Pkg::memOkT              memOk;

	ex1Pkg::regWriteT           rnWrite;
	ex1Pkg::crWriteT            cnWrite;
	ex1Pkg::memReqT             memReq;
	logic [`EX1_XLEN-1:0]       srOut;
	logic [`EX1_VA_BITS-1:0]    lrOut;
	logic [`EX1_GR_ID_BITS-1:0] heldIdRn;
	ex1Pkg::holdT               exHold;
	logic [15:0]                trapCode;

	int unsigned edgeCount;
	int          errorCount;
	int          checkCount;
	logic        timedOut;
	logic [31:0] rngState;

	ex1Stage u_dut (
		.clock       (clock),
		.rstN        (rstN),
		.opCmd       (opCmd),
		.opIxt       (opIxt),
		.ops         (ops),
		.imm         (imm),
		.pc          (pc),
		.srIn        (srIn),
		.dlrIn       (dlrIn),
		.lrIn        (lrIn),
		.braFlush    (braFlush),
		.preBra      (preBra),
		.inException (inException),
		.memOk       (memOk),
		.rnWrite     (rnWrite),
		.cnWrite     (cnWrite),
		.memReq      (memReq),
		.srOut       (srOut),
		.lrOut       (lrOut),
		.heldIdRn    (heldIdRn),
		.exHold      (exHold),
		.trapCode    (trapCode)
	);

	always #5 clock = ~clock;

	// updates in the NBA region, so a poll one unit later sees the new edge
	always @(posedge clock)
		edgeCount <= edgeCount + 1;

	// returns one time unit after the next rising edge
	task automatic waitNextEdge();
		int unsigned startCount;
		int guard;
		startCount = edgeCount;
		guard = 0;
		if (timedOut)
			return;
		while ((edgeCount == startCount) && (guard < EdgeTimeout)) begin
			#1;
			guard++;
		end
		if (edgeCount == startCount) begin
			$display("no rising clock edge seen within %0d time units", EdgeTimeout);
			timedOut = 1'b1;
			errorCount++;
		end
	endtask

	// from edge + 1 to edge + 9
	task automatic settle();
		#8;
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [63:0] nextRand();
		logic [31:0] hi;
		rngState = xorshift(rngState);
		hi = rngState;
		rngState = xorshift(rngState);
		return {hi, rngState};
	endfunction

	task automatic setIdle();
		opCmd.cc    = ex1Pkg::CC_AL;
		opCmd.cmd   = ex1Pkg::UCMD_NOP;
		opIxt       = '0;
		ops         = '0;
		ops.idRm    = `EX1_GR_ZZR;
		imm         = '0;
		pc          = '0;
		srIn        = '0;
		dlrIn       = '0;
		lrIn        = '0;
		braFlush    = 1'b0;
		preBra      = 1'b0;
		inException = 1'b0;
		memOk       = ex1Pkg::MEM_OK;
	endtask

	task automatic randomOperands();
		logic [63:0] r;
		r = nextRand();
		// ids 1 to 16, never the no-register id
		ops.idRm   = {2'b00, r[3:0]} + 6'd1;
		ops.valRs  = nextRand();
		ops.valRt  = nextRand();
		ops.valRm  = nextRand();
		ops.valCRm = nextRand();
		r = nextRand();
		pc = r[47:0];
		r = nextRand();
		lrIn = r[47:0];
	endtask

	function automatic ex1Pkg::regWriteT makeRegWrite(input logic [5:0] id,
			input logic [63:0] val);
		ex1Pkg::regWriteT w;
		w.id = id;
		w.val = val;
		return w;
	endfunction

	function automatic ex1Pkg::crWriteT makeCrWrite(input logic [4:0] id,
			input logic [63:0] val);
		ex1Pkg::crWriteT w;
		w.id = id;
		w.val = val;
		return w;
	endfunction

	function automatic ex1Pkg::memReqT makeMemReq(input logic [47:0] addr,
			input ex1Pkg::memOpmT opm, input logic [63:0] data);
		ex1Pkg::memReqT m;
		m.addr = addr;
		m.opm = opm;
		m.data = data;
		return m;
	endfunction

	function automatic ex1Pkg::holdT makeHold(input logic regHeld, input logic stall);
		ex1Pkg::holdT h;
		h.regHeld = regHeld;
		h.stall = stall;
		return h;
	endfunction

	// base plus index scaled by the access size
	function automatic logic [47:0] expectedAddr(input logic [63:0] rs,
			input logic [63:0] rt, input logic [1:0] size);
		logic [47:0] index;
		index = rt[47:0] << size;
		return rs[47:0] + index;
	endfunction

	task automatic checkRegWrite(input string what, input ex1Pkg::regWriteT expected);
		checkCount++;
		if (rnWrite !== expected) begin
			errorCount++;
			$display("FAIL rnWrite %s: expected %h, got %h", what, expected, rnWrite);
		end
	endtask

	task automatic checkCrWrite(input string what, input ex1Pkg::crWriteT expected);
		checkCount++;
		if (cnWrite !== expected) begin
			errorCount++;
			$display("FAIL cnWrite %s: expected %h, got %h", what, expected, cnWrite);
		end
	endtask

	task automatic checkMemReq(input string what, input ex1Pkg::memReqT expected);
		checkCount++;
		if (memReq !== expected) begin
			errorCount++;
			$display("FAIL memReq %s: expected %h, got %h", what, expected, memReq);
		end
	endtask

	task automatic checkSr(input string what, input logic [63:0] expected);
		checkCount++;
		if (srOut !== expected) begin
			errorCount++;
			$display("FAIL srOut %s: expected %h, got %h", what, expected, srOut);
		end
	endtask

	task automatic checkLr(input string what, input logic [47:0] expected);
		checkCount++;
		if (lrOut !== expected) begin
			errorCount++;
			$display("FAIL lrOut %s: expected %h, got %h", what, expected, lrOut);
		end
	endtask

	task automatic checkTrap(input string what, input logic [15:0] expected);
		checkCount++;
		if (trapCode !== expected) begin
			errorCount++;
			$display("FAIL trapCode %s: expected %h, got %h", what, expected, trapCode);
		end
	endtask

	task automatic checkHold(input string what, input ex1Pkg::holdT expected);
		checkCount++;
		if (exHold !== expected) begin
			errorCount++;
			$display("FAIL exHold %s: expected %h, got %h", what, expected, exHold);
		end
	endtask

	task automatic checkHeld(input string what, input logic [5:0] expected);
		checkCount++;
		if (heldIdRn !== expected) begin
			errorCount++;
			$display("FAIL heldIdRn %s: expected %h, got %h", what, expected, heldIdRn);
		end
	endtask

	task automatic testPredication();
		logic enabled;
		waitNextEdge();
		setIdle();
		settle();
		checkRegWrite("idle", makeRegWrite(`EX1_GR_ZZR, '0));
		checkCrWrite("idle", makeCrWrite(`EX1_CR_ZZR, '0));
		checkMemReq("idle", makeMemReq('0, '0, '0));
		checkHold("idle", makeHold(1'b0, 1'b0));
		checkHeld("idle", `EX1_GR_ZZR);
		checkTrap("idle", 16'h0000);
		for (int cc = 0; cc < 4; cc++) begin
			for (int t = 0; t < 2; t++) begin
				waitNextEdge();
				setIdle();
				randomOperands();
				opCmd.cc = ex1Pkg::ccT'(cc[1:0]);
				opCmd.cmd = ex1Pkg::UCMD_MOV_RC;
				srIn[`EX1_SR_T] = t[0];
				settle();
				enabled = (opCmd.cc == ex1Pkg::CC_AL) ||
					((opCmd.cc == ex1Pkg::CC_CT) && srIn[`EX1_SR_T]) ||
					((opCmd.cc == ex1Pkg::CC_CF) && !srIn[`EX1_SR_T]);
				if (enabled)
					checkCrWrite("MOV_RC enabled", makeCrWrite(ops.idRm[4:0], ops.valRs));
				else
					checkCrWrite("MOV_RC skipped", makeCrWrite(`EX1_CR_ZZR, '0));
				checkRegWrite("MOV_RC", makeRegWrite(`EX1_GR_ZZR, '0));
			end
		end
		for (int pb = 0; pb < 2; pb++) begin
			waitNextEdge();
			setIdle();
			randomOperands();
			opCmd.cmd = ex1Pkg::UCMD_BRA;
			braFlush = 1'b1;
			preBra = pb[0];
			settle();
			checkCrWrite("flushed BRA", makeCrWrite(`EX1_CR_ZZR, '0));
			checkHold("flushed BRA", makeHold(1'b0, 1'b0));
			// skipped branch that was predicted taken refetches from pc
			waitNextEdge();
			setIdle();
			randomOperands();
			opCmd.cc = ex1Pkg::CC_NV;
			opCmd.cmd = ex1Pkg::UCMD_BRA;
			preBra = pb[0];
			settle();
			if (preBra)
				checkCrWrite("skipped BRA", makeCrWrite(`EX1_CR_PC, {16'h0000, pc}));
			else
				checkCrWrite("skipped BRA", makeCrWrite(`EX1_CR_ZZR, '0));
		end
	endtask

	task automatic immMoveCase(input logic [3:0] mode, input logic immSign);
		logic [63:0] r;
		logic [63:0] expVal;
		waitNextEdge();
		setIdle();
		randomOperands();
		r = nextRand();
		imm = {immSign, r[31:0]};
		opCmd.cmd = ex1Pkg::UCMD_MOV_IR;
		opIxt = {4'h0, mode};
		settle();
		case (mode)
			`EX1_IMM_LDI:     expVal = imm[32] ? {31'h7FFF_FFFF, imm} : {31'h0, imm};
			`EX1_IMM_LDISH8:  expVal = (ops.valRs << 8) | {56'h0, imm[7:0]};
			`EX1_IMM_LDISH16: expVal = (ops.valRs << 16) | {48'h0, imm[15:0]};
			`EX1_IMM_LDISH32: expVal = (ops.valRs << 32) | {32'h0, imm[31:0]};
			default:          expVal = ops.valRt;
		endcase
		checkRegWrite($sformatf("MOV_IR mode %h", mode), makeRegWrite(ops.idRm, expVal));
		checkCrWrite("MOV_IR", makeCrWrite(`EX1_CR_ZZR, '0));
	endtask

	task automatic testImmediateMoves();
		immMoveCase(`EX1_IMM_LDI, 1'b1);
		immMoveCase(`EX1_IMM_LDI, 1'b0);
		immMoveCase(`EX1_IMM_LDISH8, 1'b1);
		immMoveCase(`EX1_IMM_LDISH16, 1'b0);
		immMoveCase(`EX1_IMM_LDISH32, 1'b1);
		immMoveCase(`EX1_IMM_JLDIX, 1'b0);
		immMoveCase(4'h9, 1'b1);
		waitNextEdge();
		setIdle();
		randomOperands();
		opCmd.cmd = ex1Pkg::UCMD_MOV_RC;
		settle();
		checkCrWrite("MOV_RC", makeCrWrite(ops.idRm[4:0], ops.valRs));
		waitNextEdge();
		setIdle();
		randomOperands();
		opCmd.cmd = ex1Pkg::UCMD_MOV_CR;
		settle();
		checkRegWrite("MOV_CR", makeRegWrite(ops.idRm, ops.valCRm));
	endtask

	task automatic memoryCase(input logic [1:0] size, input logic isLoad,
			input ex1Pkg::memOkT status);
		logic [63:0] r;
		ex1Pkg::memOpmT opm;
		ex1Pkg::memReqT expReq;
		string what;
		waitNextEdge();
		setIdle();
		randomOperands();
		r = nextRand();
		if (isLoad)
			opCmd.cmd = ex1Pkg::UCMD_MOV_MR;
		else
			opCmd.cmd = ex1Pkg::UCMD_MOV_RM;
		opIxt.mem.size = size;
		opIxt.mem.zext = r[0];
		memOk = status;
		settle();
		what = $sformatf("%s size %0d status %s", opCmd.cmd.name(), size, status.name());
		opm.dir = isLoad ? `EX1_MEM_DIR_READ : `EX1_MEM_DIR_WRITE;
		opm.ext = r[0];
		opm.size = size;
		expReq = makeMemReq(expectedAddr(ops.valRs, ops.valRt, size), opm, ops.valRm);
		checkMemReq(what, expReq);
		checkHeld(what, isLoad ? ops.idRm : `EX1_GR_ZZR);
		checkHold(what, makeHold(isLoad, status == ex1Pkg::MEM_HOLD));
		// upstream holds its inputs, request must stay put
		if (status == ex1Pkg::MEM_HOLD) begin
			waitNextEdge();
			settle();
			checkMemReq({what, " repeat"}, expReq);
			checkHold({what, " repeat"}, makeHold(isLoad, 1'b1));
		end
	endtask

	task automatic testMemory();
		logic [63:0] r;
		logic [47:0] addr;
		for (int sz = 0; sz < 4; sz++) begin
			memoryCase(sz[1:0], 1'b0, ex1Pkg::MEM_OK);
			memoryCase(sz[1:0], 1'b1, ex1Pkg::MEM_OK);
		end
		memoryCase(2'd2, 1'b1, ex1Pkg::MEM_HOLD);
		memoryCase(2'd3, 1'b0, ex1Pkg::MEM_HOLD);
		memoryCase(2'd1, 1'b1, ex1Pkg::MEM_FAULT);
		waitNextEdge();
		setIdle();
		randomOperands();
		r = nextRand();
		opCmd.cmd = ex1Pkg::UCMD_LEA_MR;
		opIxt.mem.size = r[1:0];
		settle();
		addr = expectedAddr(ops.valRs, ops.valRt, r[1:0]);
		checkRegWrite("LEA", makeRegWrite(ops.idRm, {16'h0000, addr}));
		checkMemReq("LEA", makeMemReq(addr, '0, ops.valRm));
		checkHold("LEA", makeHold(1'b0, 1'b0));
	endtask

	task automatic branchCase(input ex1Pkg::uCmdT cmd, input logic predicted);
		logic [63:0] r;
		logic [47:0] target;
		logic takes;
		logic links;
		string what;
		waitNextEdge();
		setIdle();
		randomOperands();
		r = nextRand();
		opCmd.cmd = cmd;
		opIxt.mem.size = r[1:0];
		preBra = predicted;
		settle();
		what = $sformatf("%s preBra %0d", cmd.name(), predicted);
		links = (cmd == ex1Pkg::UCMD_BSR) || (cmd == ex1Pkg::UCMD_JSR);
		if ((cmd == ex1Pkg::UCMD_JMP) || (cmd == ex1Pkg::UCMD_JSR)) begin
			target = ops.valRs[47:0];
			takes = 1'b1;
		end else begin
			target = expectedAddr(ops.valRs, ops.valRt, r[1:0]);
			takes = !predicted;
		end
		if (takes)
			checkCrWrite(what, makeCrWrite(`EX1_CR_PC, {16'h0000, target}));
		else
			checkCrWrite(what, makeCrWrite(`EX1_CR_ZZR, '0));
		checkLr(what, links ? pc : lrIn);
		checkHold(what, makeHold(1'b0, 1'b0));
	endtask

	task automatic testBranches();
		for (int pb = 0; pb < 2; pb++) begin
			branchCase(ex1Pkg::UCMD_BRA, pb[0]);
			branchCase(ex1Pkg::UCMD_BSR, pb[0]);
			branchCase(ex1Pkg::UCMD_JMP, pb[0]);
			branchCase(ex1Pkg::UCMD_JSR, pb[0]);
		end
	endtask

	task automatic controlCase(input logic [5:0] subCode, input logic excActive);
		logic [63:0] expSr;
		logic [15:0] expTrap;
		logic expStall;
		string what;
		waitNextEdge();
		setIdle();
		randomOperands();
		srIn = nextRand();
		dlrIn = nextRand();
		inException = excActive;
		opCmd.cmd = ex1Pkg::UCMD_OP_IXT;
		opIxt.ctrl.sub = ex1Pkg::ixtSubT'(subCode);
		settle();
		what = $sformatf("sub-op %h exception %0d", subCode, excActive);
		expSr = srIn;
		expTrap = 16'h0000;
		expStall = 1'b0;
		case (subCode)
			`EX1_IXT_CLRT:  expSr[`EX1_SR_T] = 1'b0;
			`EX1_IXT_SETT:  expSr[`EX1_SR_T] = 1'b1;
			`EX1_IXT_CLRS:  expSr[`EX1_SR_S] = 1'b0;
			`EX1_IXT_SETS:  expSr[`EX1_SR_S] = 1'b1;
			`EX1_IXT_NOTT:  expSr[`EX1_SR_T] = ~srIn[`EX1_SR_T];
			`EX1_IXT_NOTS:  expSr[`EX1_SR_S] = ~srIn[`EX1_SR_S];
			`EX1_IXT_RTE:   expTrap = `EX1_TRAP_RTE;
			`EX1_IXT_TRAPA: expTrap = {`EX1_TRAP_TRAPA_BASE, ops.idRm[3:0]};
			`EX1_IXT_SYSE:  expTrap = {`EX1_TRAP_SYSE_TAG, dlrIn[11:0]};
			`EX1_IXT_BREAK: expStall = !excActive;
			`EX1_IXT_NOP, `EX1_IXT_SLEEP: expStall = 1'b0;
			default:        expStall = 1'b1;
		endcase
		checkSr(what, expSr);
		checkTrap(what, expTrap);
		checkHold(what, makeHold(1'b0, expStall));
	endtask

	task automatic commandCase(input ex1Pkg::uCmdT cmd, input logic expStall,
			input logic expHeld);
		string what;
		waitNextEdge();
		setIdle();
		randomOperands();
		opCmd.cmd = cmd;
		settle();
		what = $sformatf("command %h", cmd);
		checkHold(what, makeHold(expHeld, expStall));
		checkHeld(what, expHeld ? ops.idRm : `EX1_GR_ZZR);
		checkRegWrite(what, makeRegWrite(`EX1_GR_ZZR, '0));
		checkCrWrite(what, makeCrWrite(`EX1_CR_ZZR, '0));
	endtask

	task automatic testControlOps();
		logic [5:0] subList [11];
		subList = '{`EX1_IXT_CLRT, `EX1_IXT_SETT, `EX1_IXT_CLRS, `EX1_IXT_SETS,
			`EX1_IXT_NOTT, `EX1_IXT_NOTS, `EX1_IXT_RTE, `EX1_IXT_TRAPA,
			`EX1_IXT_SYSE, `EX1_IXT_NOP, `EX1_IXT_SLEEP};
		for (int i = 0; i < 11; i++)
			controlCase(subList[i], 1'b0);
		controlCase(`EX1_IXT_BREAK, 1'b0);
		controlCase(`EX1_IXT_BREAK, 1'b1);
		controlCase(6'h3A, 1'b0);
		commandCase(ex1Pkg::UCMD_INVOP, 1'b1, 1'b0);
		commandCase(ex1Pkg::uCmdT'(6'h2F), 1'b1, 1'b0);
		commandCase(ex1Pkg::UCMD_ALU3, 1'b0, 1'b1);
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		edgeCount = 0;
		errorCount = 0;
		checkCount = 0;
		timedOut = 1'b0;
		rngState = 32'h842c_97ad;
		setIdle();
		for (int i = 0; i < 8; i++)
			waitNextEdge();
		rstN = 1'b1;
		testPredication();
		testImmediateMoves();
		testMemory();
		testBranches();
		testControlOps();
		waitNextEdge();
		$display("checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: ex1Stage.f
+incdir+hdl
hdl/ex1Pkg.sv
hdl/exPredicate.sv
hdl/exAgu.sv
hdl/exControlOps.sv
hdl/exDispatch.sv
hdl/ex1Stage.sv
dv/ex1StageTb.sv

// File: Makefile
# Verilator build and run for the ex1 stage testbench

VERILATOR ?= verilator
TOP       ?= ex1StageTb
FILELIST  ?= ex1Stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass message shows up as a line of its own
run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
